// File: project.f
src/fpu_pkg.sv
src/fp_operand_sel.sv
src/fp_simple_unit.sv
src/fpu_lane_pair.sv
src/cvt_fp_int.sv
src/fpu_cluster.sv
sim/fpu_cluster_asserts.sv
sim/fpu_cluster_check.sv
sim/fpu_cluster_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module fpu_cluster_tb -o fpu_cluster_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/fpu_cluster_sim +verilator+error+limit+100)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

// File: sim/fpu_cluster_asserts.sv
`timescale 1ns/10ps

module fpu_cluster_asserts
  import fpu_pkg::*;
#(
  parameter int N_LANES = 6
) (
  input logic                    clk,
  input logic                    rst_n,
  input logic [N_LANES*FP_W-1:0] res,
  input logic [N_LANES-1:0]      ret_en,
  input logic [FP_W-1:0]         cvt_res,
  input logic                    cvt_valid,
  input logic                    cvt_hold
);

  int fail_count = 0;

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (ret_en == '0) && !cvt_valid)
    else begin
      fail_count++;
      $error("result strobe high while reset is asserted");
    end

  for (genvar l = 0; l < N_LANES; l++) begin : g_lane
    a_res_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(ret_en[l]) && (!ret_en[l] || !$isunknown(res[l*FP_W +: FP_W])))
      else begin
        fail_count++;
        $error("lane %0d strobe or result is unknown", l);
      end
  end

  a_cvt_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(cvt_valid) && (!cvt_valid || !$isunknown(cvt_res)))
    else begin
      fail_count++;
      $error("converter strobe or result is unknown");
    end

  // A held converter keeps its output strobe where it was.
  a_hold_freezes: assert property (@(posedge clk) disable iff (!rst_n)
    cvt_hold |=> $stable(cvt_valid))
    else begin
      fail_count++;
      $error("cvt_valid changed while cvt_hold was high");
    end

endmodule

bind fpu_cluster fpu_cluster_asserts #(
  .N_LANES (N_LANES)
) asserts_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .res       (res),
  .ret_en    (ret_en),
  .cvt_res   (cvt_res),
  .cvt_valid (cvt_valid),
  .cvt_hold  (cvt_hold)
);

// File: sim/fpu_cluster_check.sv
`timescale 1ns/10ps

module fpu_cluster_check
  import fpu_pkg::*;
#(
  parameter int N_LANES = 6
) (
  input logic                      clk,
  input logic                      rst_n,
  input logic [N_LANES-1:0]        en,
  input logic [N_LANES*OP_W-1:0]   op,
  input logic [N_LANES*FP_W-1:0]   a,
  input logic [N_LANES*FP_W-1:0]   b,
  input logic [N_LANES*FWD_W-1:0]  fwd_a,
  input logic [N_LANES*FWD_W-1:0]  fwd_b,
  input logic                      cvt_hold,
  input logic [N_LANES*FP_W-1:0]   res,
  input logic [N_LANES*FLAG_W-1:0] ret,
  input logic [N_LANES-1:0]        ret_en,
  input logic [FP_W-1:0]           cvt_res,
  input logic                      cvt_flag,
  input logic                      cvt_valid
);

  localparam int LAST = N_LANES - 1;

  logic [FLAG_W+FP_W-1:0] lane_exp [N_LANES][$];
  int                     lane_at [N_LANES][$];
  logic [FP_W:0]          cvt_exp [$];
  int                     cvt_at [$];
  // Last result of each lane as the model sees it, for forwarding.
  logic [FP_W-1:0]        seen_res [N_LANES];

  string cur_test = "idle";
  bit    cvt_lat_on = 1'b0;
  int    cycle = 0;
  int    checks = 0;
  int    errors = 0;
  int    test_checks = 0;
  int    test_errors = 0;

  function automatic bit is_nan(input logic [FP_W-1:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 0);
  endfunction

  // Total order by sign and magnitude, -0 below +0.
  function automatic bit ordered_less(input logic [FP_W-1:0] x, input logic [FP_W-1:0] y);
    if (x[31] != y[31]) return x[31];
    if (!x[31]) return x[30:0] < y[30:0];
    return x[30:0] > y[30:0];
  endfunction

  function automatic logic [FLAG_W+FP_W-1:0] lane_ref(input logic [OP_W-1:0] code,
                                                      input logic [FP_W-1:0] x,
                                                      input logic [FP_W-1:0] y);
    logic [FP_W-1:0]   r;
    logic [FLAG_W-1:0] f;
    bit                nan;
    bit                zeros;
    nan   = is_nan(x) || is_nan(y);
    zeros = (x[30:0] == 0) && (y[30:0] == 0);
    r     = '0;
    f     = '0;
    case (code)
      OP_MIN, OP_MAX: begin
        if (nan) begin
          r           = CANON_NAN;
          f[FLAG_INV] = 1'b1;
        end else if (code == OP_MIN) begin
          r = ordered_less(x, y) ? x : y;
        end else begin
          r = ordered_less(x, y) ? y : x;
        end
      end
      OP_NEG: r = x ^ 32'h8000_0000;
      OP_ABS: r = x & 32'h7FFF_FFFF;
      OP_CMPLT: begin
        f[FLAG_INV] = nan;
        r[0]        = !nan && !zeros && ordered_less(x, y);
      end
      OP_CMPEQ: begin
        f[FLAG_INV] = nan;
        r[0]        = !nan && (zeros || (x == y));
      end
      default: r = '0;
    endcase
    f[FLAG_ZERO] = (r[30:0] == 0);
    return {f, r};
  endfunction

  // Returns {flag, result} of a truncating conversion to int32.
  function automatic logic [FP_W:0] cvt_ref(input logic [FP_W-1:0] x);
    logic [63:0] m;
    int          e;
    e = int'(x[30:23]);
    if (is_nan(x)) return {1'b1, INT_MAX};
    if (x == 32'hCF00_0000) return {1'b0, INT_MIN};
    if (e >= 158) return {1'b1, x[31] ? INT_MIN : INT_MAX};
    if (e < 127) return '0;
    m = {40'b0, 1'b1, x[22:0]};
    if (e >= 150) m = m << (e - 150);
    else m = m >> (150 - e);
    return {1'b0, x[31] ? -m[31:0] : m[31:0]};
  endfunction

  function automatic int outstanding();
    int n;
    n = cvt_exp.size();
    for (int l = 0; l < N_LANES; l++) n += lane_exp[l].size();
    return n;
  endfunction

  task automatic tally(input bit ok);
    checks++;
    test_checks++;
    if (!ok) begin
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test();
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  always @(posedge clk or negedge rst_n) begin : watch
    logic [FLAG_W+FP_W-1:0] want;
    logic [FP_W:0]          cwant;
    logic [FP_W-1:0]        opa;
    logic [FP_W-1:0]        opb;
    logic [OP_W-1:0]        code;
    int                     sel;
    int                     at;
    if (!rst_n) begin
      for (int l = 0; l < N_LANES; l++) begin
        lane_exp[l].delete();
        lane_at[l].delete();
        seen_res[l] = '0;
      end
      cvt_exp.delete();
      cvt_at.delete();
    end else begin
      cycle++;
      // Strobes first, so forwarded values reflect results written before this edge.
      for (int l = 0; l < N_LANES; l++) begin
        if (ret_en[l]) begin
          if (lane_exp[l].size() == 0) begin
            $display("%s: lane %0d returned a result with nothing outstanding", cur_test, l);
            tally(1'b0);
          end else begin
            want = lane_exp[l].pop_front();
            at   = lane_at[l].pop_front();
            seen_res[l] = want[FP_W-1:0];
            if ({ret[l*FLAG_W +: FLAG_W], res[l*FP_W +: FP_W]} !== want) begin
              $display("ERR %s lane %0d: expected %h, actual %h", cur_test, l, want,
                       {ret[l*FLAG_W +: FLAG_W], res[l*FP_W +: FP_W]});
              tally(1'b0);
            end else if (cycle - at != 3) begin
              $display("%s: lane %0d result came %0d cycles after issue instead of 2",
                       cur_test, l, cycle - at - 1);
              tally(1'b0);
            end else begin
              tally(1'b1);
            end
          end
        end
      end
      // A held converter shows the same result again, so only count it when it moves on.
      if (cvt_valid && !cvt_hold) begin
        if (cvt_exp.size() == 0) begin
          $display("%s: converter returned a result with nothing outstanding", cur_test);
          tally(1'b0);
        end else begin
          cwant = cvt_exp.pop_front();
          at    = cvt_at.pop_front();
          if ({cvt_flag, cvt_res} !== cwant) begin
            $display("ERR %s cvt: expected %h, actual %h", cur_test, cwant, {cvt_flag, cvt_res});
            tally(1'b0);
          end else if (cvt_lat_on && (cycle - at != 4)) begin
            $display("%s: conversion came %0d cycles after issue instead of 3",
                     cur_test, cycle - at - 1);
            tally(1'b0);
          end else begin
            tally(1'b1);
          end
        end
      end
      for (int l = 0; l < N_LANES; l++) begin
        code = op[l*OP_W +: OP_W];
        if (en[l] && (code <= OP_CMPEQ)) begin
          sel = int'(fwd_a[l*FWD_W +: FWD_W]);
          opa = (sel < N_LANES) ? seen_res[sel] : a[l*FP_W +: FP_W];
          sel = int'(fwd_b[l*FWD_W +: FWD_W]);
          opb = (sel < N_LANES) ? seen_res[sel] : b[l*FP_W +: FP_W];
          lane_exp[l].push_back(lane_ref(code, opa, opb));
          lane_at[l].push_back(cycle);
        end
      end
      if (en[LAST] && (op[LAST*OP_W +: OP_W] == OP_CVT)) begin
        cvt_exp.push_back(cvt_ref(a[LAST*FP_W +: FP_W]));
        cvt_at.push_back(cycle);
      end
    end
  end

endmodule

// File: sim/fpu_cluster_tb.sv
`timescale 1ns/10ps

module fpu_cluster_tb
  import fpu_pkg::*;
;

  localparam int N_PAIRS = 3;
  localparam int N_LANES = 2 * N_PAIRS;
  localparam int LAST    = N_LANES - 1;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic [N_LANES-1:0]        en;
  logic [N_LANES*OP_W-1:0]   op;
  logic [N_LANES*FP_W-1:0]   a;
  logic [N_LANES*FP_W-1:0]   b;
  logic [N_LANES*FWD_W-1:0]  fwd_a;
  logic [N_LANES*FWD_W-1:0]  fwd_b;
  logic                      cvt_hold;
  logic [N_LANES*FP_W-1:0]   res;
  logic [N_LANES*FLAG_W-1:0] ret;
  logic [N_LANES-1:0]        ret_en;
  logic [FP_W-1:0]           cvt_res;
  logic                      cvt_flag;
  logic                      cvt_valid;

  integer seed = 32'h9771;
  int     tests_done = 0;
  int     tb_errors = 0;
  bit     hold_pat [0:63];

  logic [FP_W-1:0] specials [0:7] = '{32'h0000_0000, 32'h8000_0000, 32'h7FC0_0000,
                                      32'h7F80_0001, 32'h7F80_0000, 32'hFF80_0000,
                                      32'h3F80_0000, 32'hBF80_0000};

  always #5 clk = ~clk;

  fpu_cluster #(.N_PAIRS(N_PAIRS)) dut_i (.*);

  fpu_cluster_check #(.N_LANES(N_LANES)) check_i (.*);

  // Advances one cycle and clears the per-cycle strobes and selects.
  task automatic tick();
    @(posedge clk);
    #1;
    en    = '0;
    fwd_a = {N_LANES{FWD_NONE}};
    fwd_b = {N_LANES{FWD_NONE}};
  endtask

  task automatic set_lane(input int l, input logic [OP_W-1:0] code, input logic [FP_W-1:0] x,
                          input logic [FP_W-1:0] y, input logic [FWD_W-1:0] fx,
                          input logic [FWD_W-1:0] fy);
    en[l]                 = 1'b1;
    op[l*OP_W +: OP_W]    = code;
    a[l*FP_W +: FP_W]     = x;
    b[l*FP_W +: FP_W]     = y;
    fwd_a[l*FWD_W +: FWD_W] = fx;
    fwd_b[l*FWD_W +: FWD_W] = fy;
  endtask

  // Mostly random words, about one in four from the special list.
  task automatic rand_word(output logic [FP_W-1:0] w);
    logic [31:0] r;
    r = $random(seed);
    if (r[1:0] == 2'd0) w = specials[r[6:4]];
    else w = $random(seed);
  endtask

  task automatic rand_cvt_word(output logic [FP_W-1:0] w);
    logic [31:0] r;
    r = $random(seed);
    w = {r[31], 8'd127 + {3'b0, r[27:23]}, r[22:0]};
  endtask

  task automatic run_test(input string name);
    check_i.cur_test = name;
  endtask

  task automatic finish_test();
    for (int i = 0; i < 50 && check_i.outstanding() != 0; i++) tick();
    if (check_i.outstanding() != 0) begin
      $display("%s: timed out with %0d results still outstanding", check_i.cur_test,
               check_i.outstanding());
      tb_errors++;
    end
    check_i.report_test();
    tests_done++;
  endtask

  initial begin : stimulus
    logic [FP_W-1:0] x;
    logic [FP_W-1:0] y;
    logic [31:0]     r;
    rst_n    = 1'b0;
    en       = '0;
    op       = '0;
    a        = '0;
    b        = '0;
    fwd_a    = {N_LANES{FWD_NONE}};
    fwd_b    = {N_LANES{FWD_NONE}};
    cvt_hold = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_test("minmax");
    tick();
    set_lane(0, OP_MIN, 32'h0000_0000, 32'h8000_0000, FWD_NONE, FWD_NONE);
    set_lane(1, OP_MAX, 32'h0000_0000, 32'h8000_0000, FWD_NONE, FWD_NONE);
    set_lane(2, OP_MIN, 32'h8000_0000, 32'h0000_0000, FWD_NONE, FWD_NONE);
    set_lane(3, OP_NEG, 32'h0000_0000, 32'h0, FWD_NONE, FWD_NONE);
    set_lane(4, OP_ABS, 32'hBF80_0000, 32'h0, FWD_NONE, FWD_NONE);
    set_lane(5, OP_MAX, 32'hBF80_0000, 32'hC000_0000, FWD_NONE, FWD_NONE);
    for (int c = 0; c < 40; c++) begin
      tick();
      for (int l = 0; l < N_LANES; l++) begin
        r = $random(seed);
        rand_word(x);
        rand_word(y);
        set_lane(l, {1'b0, r[1:0]}, x, y, FWD_NONE, FWD_NONE);
      end
    end
    finish_test();

    run_test("nan_flags");
    tick();
    set_lane(0, OP_MIN, 32'h7F80_0001, 32'h3F80_0000, FWD_NONE, FWD_NONE);
    set_lane(1, OP_MAX, 32'h3F80_0000, 32'hFFC0_0000, FWD_NONE, FWD_NONE);
    set_lane(2, OP_CMPLT, 32'h7FC0_0000, 32'h0, FWD_NONE, FWD_NONE);
    set_lane(3, OP_CMPEQ, 32'h7FC0_0000, 32'h7FC0_0000, FWD_NONE, FWD_NONE);
    set_lane(4, OP_ABS, 32'h8000_0000, 32'h0, FWD_NONE, FWD_NONE);
    set_lane(5, OP_NEG, 32'h7FC0_0000, 32'h0, FWD_NONE, FWD_NONE);
    tick();
    set_lane(0, OP_MIN, 32'h0000_0000, 32'h0000_0000, FWD_NONE, FWD_NONE);
    set_lane(3, OP_NEG, 32'h8000_0000, 32'h0, FWD_NONE, FWD_NONE);
    finish_test();

    run_test("compare");
    tick();
    set_lane(0, OP_CMPLT, 32'h8000_0000, 32'h0000_0000, FWD_NONE, FWD_NONE);
    set_lane(1, OP_CMPEQ, 32'h8000_0000, 32'h0000_0000, FWD_NONE, FWD_NONE);
    set_lane(2, OP_CMPLT, 32'hBF80_0000, 32'h3F80_0000, FWD_NONE, FWD_NONE);
    set_lane(3, OP_CMPLT, 32'h3F80_0000, 32'hBF80_0000, FWD_NONE, FWD_NONE);
    set_lane(4, OP_CMPEQ, 32'h3F80_0000, 32'h3F80_0000, FWD_NONE, FWD_NONE);
    set_lane(5, OP_CMPLT, 32'hC000_0000, 32'hBF80_0000, FWD_NONE, FWD_NONE);
    for (int c = 0; c < 30; c++) begin
      tick();
      for (int l = 0; l < N_LANES; l++) begin
        r = $random(seed);
        rand_word(x);
        rand_word(y);
        set_lane(l, r[0] ? OP_CMPEQ : OP_CMPLT, x, r[1] ? x : y, FWD_NONE, FWD_NONE);
      end
    end
    finish_test();

    run_test("forwarding");
    for (int c = 0; c < 40; c++) begin
      tick();
      for (int l = 0; l < N_LANES; l++) begin
        r = $random(seed);
        rand_word(x);
        rand_word(y);
        set_lane(l, (r[2:0] > 3'd5) ? OP_MIN : r[2:0], x, y, r[6:4], r[10:8]);
      end
    end
    finish_test();

    run_test("convert");
    check_i.cvt_lat_on = 1'b1;
    for (int c = 0; c < 36; c++) begin
      tick();
      case (c)
        0: x = 32'h3FC0_0000;
        1: x = 32'hBFC0_0000;
        2: x = 32'h47F1_2039;
        3: x = 32'h4F00_0000;
        4: x = 32'hCF00_0000;
        5: x = 32'hCF00_0001;
        6: x = 32'hCF80_0000;
        7: x = 32'h7FC0_0000;
        8: x = 32'h7F80_0000;
        9: x = 32'hFF80_0000;
        10: x = 32'h3F7F_FFFF;
        11: x = 32'h4EFF_FFFF;
        12: x = 32'h8000_0000;
        default: rand_cvt_word(x);
      endcase
      set_lane(LAST, OP_CVT, x, 32'h0, FWD_NONE, FWD_NONE);
    end
    finish_test();

    run_test("convert_hold");
    check_i.cvt_lat_on = 1'b0;
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      hold_pat[i] = (i < 60) && (r[1:0] == 2'd0);
    end
    // A convert reaches the converter one cycle after issue, so it must not
    // land on a held cycle.
    for (int c = 0; c < 60; c++) begin
      tick();
      cvt_hold = hold_pat[c];
      if (!hold_pat[c+1]) begin
        rand_cvt_word(x);
        set_lane(LAST, OP_CVT, x, 32'h0, FWD_NONE, FWD_NONE);
      end
    end
    tick();
    cvt_hold = 1'b0;
    finish_test();

    $display("%0d tests, %0d checks, %0d errors, %0d other failures, %0d assertion failures",
             tests_done, check_i.checks, check_i.errors, tb_errors,
             dut_i.asserts_i.fail_count);
    if (check_i.errors == 0 && tb_errors == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: src/cvt_fp_int.sv
`timescale 1ns/10ps

module cvt_fp_int
  import fpu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            en,
  input  logic            hold,
  input  logic [FP_W-1:0] a,
  output logic [FP_W-1:0] res,
  output logic            flag,
  output logic            valid
);

  // Biased exponents of 1.0, of a unit mantissa LSB, and of 2^31.
  localparam logic [7:0] EXP_ONE = 8'd127;
  localparam logic [7:0] EXP_INT = 8'd150;
  localparam logic [7:0] EXP_SAT = 8'd158;

  logic            in_valid;
  logic [FP_W-1:0] in_a;

  logic            s1_valid;
  logic            s1_sign;
  logic [7:0]      s1_exp;
  logic [23:0]     s1_mant;
  logic            s1_nan;

  logic [FP_W-1:0] mag;
  logic [FP_W-1:0] nxt_res;
  logic            nxt_flag;

  // Hold freezes every register of the converter, valid bits included.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_valid <= 1'b0;
      s1_valid <= 1'b0;
      valid    <= 1'b0;
    end else if (!hold) begin
      in_valid <= en;
      s1_valid <= in_valid;
      valid    <= s1_valid;
    end
  end

  // Stage one unpacks the word, stage two writes the integer result.
  always_ff @(posedge clk) begin
    if (!hold) begin
      in_a    <= a;
      s1_sign <= in_a[31];
      s1_exp  <= in_a[30:23];
      s1_mant <= {|in_a[30:23], in_a[22:0]};
      s1_nan  <= (in_a[30:23] == 8'hFF) && (in_a[22:0] != '0);
      res     <= nxt_res;
      flag    <= nxt_flag;
    end
  end

  always_comb begin
    mag      = '0;
    nxt_res  = '0;
    nxt_flag = 1'b0;
    if (s1_nan) begin
      nxt_res  = INT_MAX;
      nxt_flag = 1'b1;
    end else if (s1_exp >= EXP_SAT) begin
      nxt_res  = s1_sign ? INT_MIN : INT_MAX;
      // -2^31 itself is representable.
      nxt_flag = !(s1_sign && (s1_exp == EXP_SAT) && (s1_mant == 24'h80_0000));
    end else begin
      if (s1_exp < EXP_ONE) begin
        mag = '0;
      end else if (s1_exp >= EXP_INT) begin
        mag = {8'b0, s1_mant} << (s1_exp - EXP_INT);
      end else begin
        mag = {8'b0, s1_mant} >> (EXP_INT - s1_exp);
      end
      nxt_res = s1_sign ? -mag : mag;
    end
  end

endmodule

// File: src/fp_operand_sel.sv
`timescale 1ns/10ps

module fp_operand_sel
  import fpu_pkg::*;
#(
  parameter int N_LANES = 6
) (
  input  logic [FP_W-1:0]         direct,
  input  logic [FWD_W-1:0]        sel,
  input  logic [N_LANES*FP_W-1:0] fwd_bus,
  output logic [FP_W-1:0]         operand
);

  // The forwarded bus carries the registered lane results, so a select
  // picks whatever res value is visible in the cycle the operand is sampled.
  // Any select that names no existing lane falls back to the direct input.
  always_comb begin
    operand = direct;
    if (sel != FWD_NONE) begin
      for (int i = 0; i < N_LANES; i++) begin
        if (int'(sel) == i) begin
          operand = fwd_bus[i*FP_W +: FP_W];
        end
      end
    end
  end

endmodule

// File: src/fp_simple_unit.sv
`timescale 1ns/10ps

module fp_simple_unit
  import fpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic [OP_W-1:0]   op,
  input  logic [FP_W-1:0]   a,
  input  logic [FP_W-1:0]   b,
  output logic [FP_W-1:0]   res,
  output logic [FLAG_W-1:0] ret,
  output logic              ret_en
);

  logic              in_valid;
  logic [OP_W-1:0]   in_op;
  logic [FP_W-1:0]   in_a;
  logic [FP_W-1:0]   in_b;

  logic              nan_a;
  logic              nan_b;
  logic              both_zero;
  logic              lt_ord;

  logic              s1_valid;
  logic [OP_W-1:0]   s1_op;
  logic [FP_W-1:0]   s1_a;
  logic [FP_W-1:0]   s1_b;
  logic              s1_nan;
  logic              s1_lt_ord;
  logic              s1_cmp_lt;
  logic              s1_cmp_eq;

  logic [FP_W-1:0]   nxt_res;
  logic              nxt_inv;
  logic              known;
  logic [FLAG_W-1:0] nxt_flag;

  // Maps a sign-magnitude word onto an unsigned scale. Negative values are
  // inverted, so -0 lands one step below +0.
  function automatic logic [FP_W-1:0] order_key(input logic [FP_W-1:0] x);
    order_key = x[FP_W-1] ? ~x : (x | {1'b1, {(FP_W-1){1'b0}}});
  endfunction

  // Input register, sampled on the edge where the lane accepts the op.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_valid <= 1'b0;
    end else begin
      in_valid <= en;
    end
  end

  always_ff @(posedge clk) begin
    in_op <= op;
    in_a  <= a;
    in_b  <= b;
  end

  assign nan_a     = (in_a[30:23] == 8'hFF) && (in_a[22:0] != '0);
  assign nan_b     = (in_b[30:23] == 8'hFF) && (in_b[22:0] != '0);
  assign both_zero = (in_a[30:0] == '0) && (in_b[30:0] == '0);
  assign lt_ord    = order_key(in_a) < order_key(in_b);

  // Stage one: classification and ordering.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op     <= in_op;
    s1_a      <= in_a;
    s1_b      <= in_b;
    s1_nan    <= nan_a || nan_b;
    s1_lt_ord <= lt_ord;
    // Compares see +0 and -0 as one value.
    s1_cmp_lt <= lt_ord && !both_zero;
    s1_cmp_eq <= (in_a == in_b) || both_zero;
  end

  // Stage two: result selection.
  always_comb begin
    nxt_res = '0;
    nxt_inv = 1'b0;
    known   = 1'b1;
    case (s1_op)
      OP_MIN, OP_MAX: begin
        if (s1_nan) begin
          nxt_res = CANON_NAN;
          nxt_inv = 1'b1;
        end else if ((s1_op == OP_MIN) == s1_lt_ord) begin
          nxt_res = s1_a;
        end else begin
          nxt_res = s1_b;
        end
      end
      OP_NEG:  nxt_res = {~s1_a[FP_W-1], s1_a[FP_W-2:0]};
      OP_ABS:  nxt_res = {1'b0, s1_a[FP_W-2:0]};
      OP_CMPLT, OP_CMPEQ: begin
        nxt_inv = s1_nan;
        if (!s1_nan) begin
          nxt_res[0] = (s1_op == OP_CMPLT) ? s1_cmp_lt : s1_cmp_eq;
        end
      end
      default: known = 1'b0;
    endcase
  end

  always_comb begin
    nxt_flag            = '0;
    nxt_flag[FLAG_INV]  = nxt_inv;
    nxt_flag[FLAG_ZERO] = (nxt_res[FP_W-2:0] == '0);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_en <= 1'b0;
      res    <= '0;
      ret    <= '0;
    end else begin
      ret_en <= s1_valid && known;
      if (s1_valid && known) begin
        res <= nxt_res;
        ret <= nxt_flag;
      end
    end
  end

endmodule

// File: src/fpu_cluster.sv
`timescale 1ns/10ps

module fpu_cluster
  import fpu_pkg::*;
#(
  parameter int  N_PAIRS = 3,
  localparam int N_LANES = 2 * N_PAIRS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [N_LANES-1:0]        en,
  input  logic [N_LANES*OP_W-1:0]   op,
  input  logic [N_LANES*FP_W-1:0]   a,
  input  logic [N_LANES*FP_W-1:0]   b,
  input  logic [N_LANES*FWD_W-1:0]  fwd_a,
  input  logic [N_LANES*FWD_W-1:0]  fwd_b,
  input  logic                      cvt_hold,
  output logic [N_LANES*FP_W-1:0]   res,
  output logic [N_LANES*FLAG_W-1:0] ret,
  output logic [N_LANES-1:0]        ret_en,
  output logic [FP_W-1:0]           cvt_res,
  output logic                      cvt_flag,
  output logic                      cvt_valid
);

  localparam int LAST = N_LANES - 1;

  logic            last_en_q;
  logic [OP_W-1:0] last_op_q;
  logic [FP_W-1:0] last_a_q;
  logic            cvt_en;

  // Each pair writes its own slice of res. The full res vector is the
  // forwarding bus seen by every pair.
  for (genvar p = 0; p < N_PAIRS; p++) begin : g_pair
    fpu_lane_pair #(
      .N_LANES (N_LANES)
    ) pair_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (en[2*p +: 2]),
      .op      (op[2*p*OP_W +: 2*OP_W]),
      .a       (a[2*p*FP_W +: 2*FP_W]),
      .b       (b[2*p*FP_W +: 2*FP_W]),
      .fwd_a   (fwd_a[2*p*FWD_W +: 2*FWD_W]),
      .fwd_b   (fwd_b[2*p*FWD_W +: 2*FWD_W]),
      .fwd_bus (res),
      .res     (res[2*p*FP_W +: 2*FP_W]),
      .ret     (ret[2*p*FLAG_W +: 2*FLAG_W]),
      .ret_en  (ret_en[2*p +: 2])
    );
  end

  // The last lane's raw inputs are captured every cycle, independent of hold.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_en_q <= 1'b0;
      last_op_q <= '0;
    end else begin
      last_en_q <= en[LAST];
      last_op_q <= op[LAST*OP_W +: OP_W];
    end
  end

  always_ff @(posedge clk) begin
    last_a_q <= a[LAST*FP_W +: FP_W];
  end

  assign cvt_en = last_en_q && (last_op_q == OP_CVT);

  cvt_fp_int cvt_i (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (cvt_en),
    .hold  (cvt_hold),
    .a     (last_a_q),
    .res   (cvt_res),
    .flag  (cvt_flag),
    .valid (cvt_valid)
  );

endmodule

// File: src/fpu_lane_pair.sv
`timescale 1ns/10ps

module fpu_lane_pair
  import fpu_pkg::*;
#(
  parameter int N_LANES = 6
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              en,
  input  logic [2*OP_W-1:0]       op,
  input  logic [2*FP_W-1:0]       a,
  input  logic [2*FP_W-1:0]       b,
  input  logic [2*FWD_W-1:0]      fwd_a,
  input  logic [2*FWD_W-1:0]      fwd_b,
  input  logic [N_LANES*FP_W-1:0] fwd_bus,
  output logic [2*FP_W-1:0]       res,
  output logic [2*FLAG_W-1:0]     ret,
  output logic [1:0]              ret_en
);

  // Both lanes see the full result bus, so either operand of either lane
  // can take the result of any lane in the cluster.
  for (genvar l = 0; l < 2; l++) begin : g_lane
    logic [FP_W-1:0] opnd_a;
    logic [FP_W-1:0] opnd_b;

    fp_operand_sel #(
      .N_LANES (N_LANES)
    ) sel_a_i (
      .direct  (a[l*FP_W +: FP_W]),
      .sel     (fwd_a[l*FWD_W +: FWD_W]),
      .fwd_bus (fwd_bus),
      .operand (opnd_a)
    );

    fp_operand_sel #(
      .N_LANES (N_LANES)
    ) sel_b_i (
      .direct  (b[l*FP_W +: FP_W]),
      .sel     (fwd_b[l*FWD_W +: FWD_W]),
      .fwd_bus (fwd_bus),
      .operand (opnd_b)
    );

    fp_simple_unit unit_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .en     (en[l]),
      .op     (op[l*OP_W +: OP_W]),
      .a      (opnd_a),
      .b      (opnd_b),
      .res    (res[l*FP_W +: FP_W]),
      .ret    (ret[l*FLAG_W +: FLAG_W]),
      .ret_en (ret_en[l])
    );
  end

endmodule

// File: src/fpu_pkg.sv
package fpu_pkg;

  // Word and field widths.
  localparam int FP_W   = 32;
  localparam int OP_W   = 3;
  localparam int FLAG_W = 2;
  localparam int FWD_W  = 3;

  // Lane operation codes. Code 7 is unused and gives no result.
  localparam logic [OP_W-1:0] OP_MIN   = 3'd0;
  localparam logic [OP_W-1:0] OP_MAX   = 3'd1;
  localparam logic [OP_W-1:0] OP_NEG   = 3'd2;
  localparam logic [OP_W-1:0] OP_ABS   = 3'd3;
  localparam logic [OP_W-1:0] OP_CMPLT = 3'd4;
  localparam logic [OP_W-1:0] OP_CMPEQ = 3'd5;
  localparam logic [OP_W-1:0] OP_CVT   = 3'd6;

  // Bit positions within the flag word.
  localparam int FLAG_INV  = 0;
  localparam int FLAG_ZERO = 1;

  // Forward select value that takes the lane's direct operand.
  localparam logic [FWD_W-1:0] FWD_NONE = 3'd7;

  localparam logic [FP_W-1:0] CANON_NAN = 32'h7FC0_0000;

  // Saturation limits of the float to integer converter.
  localparam logic [FP_W-1:0] INT_MAX = 32'h7FFF_FFFF;
  localparam logic [FP_W-1:0] INT_MIN = 32'h8000_0000;

endpackage
